// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_pcie_ep_top \
   -f verilog.f -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
   exit 0
fi
exit 1

// File: src/ast_loopback.sv
//******************************
// both stages stall together on tx_ready low
// rx is refused until bus master is enabled
//******************************

module ast_loopback (
   input  logic                   pld_clk,
   input  logic                   npor,
   input  logic                   app_rstn,
   input  logic                   bus_master_en,
   input  pcie_ep_pkg::ast_beat_t rx_beat,
   input  logic                   rx_valid,
   input  logic                   tx_ready,
   output logic                   rx_ready,
   output pcie_ep_pkg::ast_beat_t tx_beat,
   output logic                   tx_valid
);
   import pcie_ep_pkg::*;

   ast_beat_t stage1;
   ast_beat_t stage2;
   logic      valid1;
   logic      valid2;
   logic      advance;
   logic      take;

   // stage 2 drains exactly when the pipe moves
   assign advance  = tx_ready;
   assign rx_ready = tx_ready && bus_master_en && app_rstn;
   assign take     = rx_valid && rx_ready;

   always_ff @(posedge pld_clk or negedge npor) begin
      if (!npor) begin
         valid1 <= 1'b0;
         valid2 <= 1'b0;
      end else if (!app_rstn) begin
         valid1 <= 1'b0;
         valid2 <= 1'b0;
      end else if (advance) begin
         valid1 <= take;
         valid2 <= valid1;
      end
   end

   // payload follows the valid bits
   always_ff @(posedge pld_clk) begin
      if (advance) begin
         stage1 <= rx_beat;
         stage2 <= stage1;
      end
   end

   assign tx_beat  = stage2;
   assign tx_valid = valid2;

endmodule

// File: src/pcie_ep_pkg.sv
//******************************
// shared widths, codes and the stream beat type
// LTSSM and tl_cfg_add codes follow the hard IP encoding
//******************************

package pcie_ep_pkg;

   // stream payload
   typedef logic [63:0] data_t;
   typedef logic        empty_t;

   // link and configuration side
   typedef logic [4:0]  ltssm_t;
   typedef logic [3:0]  cfg_addr_t;
   typedef logic [31:0] cfg_ctl_t;
   typedef logic [12:0] busdev_t;

   // one Avalon-ST beat, valid travels beside it
   typedef struct packed {
      data_t  data;
      logic   sop;
      logic   eop;
      empty_t empty;
      logic   err;
   } ast_beat_t;

   localparam ltssm_t ltssm_l0 = 5'h0F;

   // tl_cfg_add selectors
   localparam cfg_addr_t cfg_addr_prmcsr = 4'h3;
   localparam cfg_addr_t cfg_addr_busdev = 4'hF;

   // bus master enable within the command register
   localparam int unsigned bus_master_bit = 2;

   // reset sequencing timing, in pld_clk cycles
   localparam int unsigned l0_stable_cycles = 16;
   localparam int unsigned rst_hold_cycles  = 8;

   typedef enum logic [1:0] {
      rs_hold,
      rs_wait_l0,
      rs_run
   } rst_state_t;

endpackage

// File: src/pcie_ep_top.sv
//******************************
// 64-bit Avalon-ST application side
// tx holds contents while tx_st_ready is low
//******************************

module pcie_ep_top (
   input  logic                   pld_clk,
   input  logic                   npor,
   input  logic                   rc_pll_locked,
   input  pcie_ep_pkg::ltssm_t    ltssmstate,
   input  logic                   dlup_exit,
   input  logic                   hotrst_exit,
   input  logic                   l2_exit,
   input  pcie_ep_pkg::cfg_addr_t tl_cfg_add,
   input  pcie_ep_pkg::cfg_ctl_t  tl_cfg_ctl,
   input  pcie_ep_pkg::data_t     rx_st_data,
   input  logic                   rx_st_sop,
   input  logic                   rx_st_eop,
   input  pcie_ep_pkg::empty_t    rx_st_empty,
   input  logic                   rx_st_err,
   input  logic                   rx_st_valid,
   input  logic                   tx_st_ready,
   output logic                   app_rstn,
   output logic                   crst,
   output logic                   srst,
   output pcie_ep_pkg::busdev_t   cfg_busdev,
   output logic                   rx_st_ready,
   output pcie_ep_pkg::data_t     tx_st_data,
   output logic                   tx_st_sop,
   output logic                   tx_st_eop,
   output pcie_ep_pkg::empty_t    tx_st_empty,
   output logic                   tx_st_err,
   output logic                   tx_st_valid
);
   import pcie_ep_pkg::*;

   ast_beat_t rx_beat;
   ast_beat_t tx_beat;
   logic      bus_master_en;

   assign rx_beat = '{data:  rx_st_data,
                      sop:   rx_st_sop,
                      eop:   rx_st_eop,
                      empty: rx_st_empty,
                      err:   rx_st_err};

   pcie_reset_seq rs_hip (
      .pld_clk       (pld_clk),
      .npor          (npor),
      .rc_pll_locked (rc_pll_locked),
      .ltssmstate    (ltssmstate),
      .dlup_exit     (dlup_exit),
      .hotrst_exit   (hotrst_exit),
      .l2_exit       (l2_exit),
      .app_rstn      (app_rstn),
      .crst          (crst),
      .srst          (srst)
   );

   tl_cfg_sample cfgbus (
      .pld_clk       (pld_clk),
      .npor          (npor),
      .app_rstn      (app_rstn),
      .tl_cfg_add    (tl_cfg_add),
      .tl_cfg_ctl    (tl_cfg_ctl),
      .cfg_busdev    (cfg_busdev),
      .bus_master_en (bus_master_en)
   );

   ast_loopback app (
      .pld_clk       (pld_clk),
      .npor          (npor),
      .app_rstn      (app_rstn),
      .bus_master_en (bus_master_en),
      .rx_beat       (rx_beat),
      .rx_valid      (rx_st_valid),
      .tx_ready      (tx_st_ready),
      .rx_ready      (rx_st_ready),
      .tx_beat       (tx_beat),
      .tx_valid      (tx_st_valid)
   );

   // flat tx ports from the beat struct
   assign tx_st_data  = tx_beat.data;
   assign tx_st_sop   = tx_beat.sop;
   assign tx_st_eop   = tx_beat.eop;
   assign tx_st_empty = tx_beat.empty;
   assign tx_st_err   = tx_beat.err;

endmodule

// File: src/pcie_reset_seq.sv
//******************************
// exit pulses are active low and sampled on pld_clk
// L0 stability count restarts once the crst/srst hold ends
//******************************

module pcie_reset_seq (
   input  logic                pld_clk,
   input  logic                npor,
   input  logic                rc_pll_locked,
   input  pcie_ep_pkg::ltssm_t ltssmstate,
   input  logic                dlup_exit,
   input  logic                hotrst_exit,
   input  logic                l2_exit,
   output logic                app_rstn,
   output logic                crst,
   output logic                srst
);
   import pcie_ep_pkg::*;

   typedef logic [$clog2(rst_hold_cycles)-1:0]    hold_cnt_t;
   typedef logic [$clog2(l0_stable_cycles+1)-1:0] l0_cnt_t;

   rst_state_t state;
   hold_cnt_t  hold_cnt;
   l0_cnt_t    l0_cnt;
   logic       rst_req;
   logic       exit_evt;
   logic       in_l0;
   logic       l0_stable;

   assign exit_evt  = !dlup_exit || !hotrst_exit || !l2_exit;
   assign in_l0     = (ltssmstate == ltssm_l0);
   assign l0_stable = (l0_cnt == l0_cnt_t'(l0_stable_cycles));

   always_ff @(posedge pld_clk or negedge npor) begin
      if (!npor) begin
         state    <= rs_hold;
         hold_cnt <= hold_cnt_t'(rst_hold_cycles - 1);
         l0_cnt   <= '0;
         rst_req  <= 1'b1;
         app_rstn <= 1'b0;
      end else if (!rc_pll_locked || exit_evt) begin
         // pll loss behaves like power-on, an exit pulse restarts the hold
         state    <= rs_hold;
         hold_cnt <= hold_cnt_t'(rst_hold_cycles - 1);
         l0_cnt   <= '0;
         rst_req  <= 1'b1;
         app_rstn <= 1'b0;
      end else begin
         case (state)
            rs_hold: begin
               l0_cnt <= '0;
               if (hold_cnt == '0) begin
                  state   <= rs_wait_l0;
                  rst_req <= 1'b0;
               end else begin
                  hold_cnt <= hold_cnt - 1'b1;
               end
            end
            rs_wait_l0: begin
               if (!in_l0) begin
                  l0_cnt <= '0;
               end else if (l0_stable) begin
                  state    <= rs_run;
                  app_rstn <= 1'b1;
               end else begin
                  l0_cnt <= l0_cnt + 1'b1;
               end
            end
            rs_run: begin
               // link dropped out of L0
               if (!in_l0) begin
                  state    <= rs_wait_l0;
                  l0_cnt   <= '0;
                  app_rstn <= 1'b0;
               end
            end
            default: begin
               state <= rs_hold;
            end
         endcase
      end
   end

   // core and sticky requests always move together
   assign crst = rst_req;
   assign srst = rst_req;

endmodule

// File: src/tl_cfg_sample.sv
//******************************
// tl_cfg_ctl is taken only once tl_cfg_add is seen twice
// only busdev and bus master enable are kept
//******************************

module tl_cfg_sample (
   input  logic                   pld_clk,
   input  logic                   npor,
   input  logic                   app_rstn,
   input  pcie_ep_pkg::cfg_addr_t tl_cfg_add,
   input  pcie_ep_pkg::cfg_ctl_t  tl_cfg_ctl,
   output pcie_ep_pkg::busdev_t   cfg_busdev,
   output logic                   bus_master_en
);
   import pcie_ep_pkg::*;

   cfg_addr_t add_q;
   logic      add_stable;

   // address seen on the previous edge
   always_ff @(posedge pld_clk or negedge npor) begin
      if (!npor) begin
         add_q <= '0;
      end else begin
         add_q <= tl_cfg_add;
      end
   end

   // ctl word settles while the address is held
   assign add_stable = (tl_cfg_add == add_q);

   always_ff @(posedge pld_clk or negedge npor) begin
      if (!npor) begin
         cfg_busdev    <= '0;
         bus_master_en <= 1'b0;
      end else if (!app_rstn) begin
         cfg_busdev    <= '0;
         bus_master_en <= 1'b0;
      end else if (add_stable) begin
         case (tl_cfg_add)
            cfg_addr_busdev: begin
               cfg_busdev <= tl_cfg_ctl[$bits(busdev_t)-1:0];
            end
            cfg_addr_prmcsr: begin
               // command register, bus master bit only
               bus_master_en <= tl_cfg_ctl[bus_master_bit];
            end
            default: begin
            end
         endcase
      end
   end

endmodule

// File: test/pcie_ep_asserts.sv
//******************************
// bound into every pcie_ep_top instance
// tx hold rule applies only while app_rstn is high
//******************************

module pcie_ep_asserts (
   input logic                pld_clk,
   input logic                npor,
   input logic                app_rstn,
   input logic                crst,
   input logic                srst,
   input logic                tx_st_valid,
   input logic                tx_st_ready,
   input pcie_ep_pkg::data_t  tx_st_data,
   input logic                tx_st_sop,
   input logic                tx_st_eop,
   input pcie_ep_pkg::empty_t tx_st_empty,
   input logic                tx_st_err
);
   int fail_cnt = 0;

   // valid bits clear on the edge after app_rstn falls
   tx_idle_in_reset: assert property (@(posedge pld_clk) disable iff (!npor)
      !app_rstn |=> !tx_st_valid)
      else begin
         $error("tx_st_valid high while app_rstn low");
         fail_cnt++;
      end

   crst_blocks_app: assert property (@(posedge pld_clk) disable iff (!npor)
      crst |-> !app_rstn)
      else begin
         $error("crst high while app_rstn high");
         fail_cnt++;
      end

   crst_srst_pair: assert property (@(posedge pld_clk) disable iff (!npor)
      crst == srst)
      else begin
         $error("crst and srst differ");
         fail_cnt++;
      end

   tx_hold_on_stall: assert property (@(posedge pld_clk) disable iff (!npor)
      app_rstn && tx_st_valid && !tx_st_ready |=>
         tx_st_valid &&
         $stable({tx_st_data, tx_st_sop, tx_st_eop, tx_st_empty, tx_st_err}))
      else begin
         $error("tx beat changed while stalled");
         fail_cnt++;
      end

endmodule

bind pcie_ep_top pcie_ep_asserts chk (
   .pld_clk     (pld_clk),
   .npor        (npor),
   .app_rstn    (app_rstn),
   .crst        (crst),
   .srst        (srst),
   .tx_st_valid (tx_st_valid),
   .tx_st_ready (tx_st_ready),
   .tx_st_data  (tx_st_data),
   .tx_st_sop   (tx_st_sop),
   .tx_st_eop   (tx_st_eop),
   .tx_st_empty (tx_st_empty),
   .tx_st_err   (tx_st_err)
);

// File: test/tb_pcie_ep_top.sv
//******************************
// drives pcie_ep_top through reset, config and loopback
// inputs change 2 units after each rising pld_clk edge
//******************************

module tb_pcie_ep_top;
   import pcie_ep_pkg::*;

   typedef logic [$bits(ast_beat_t)-1:0] cmp_t;

   localparam int clk_period  = 20;
   localparam int stim_cycles = 520;

   logic      pld_clk = 1'b0;
   logic      npor;
   logic      rc_pll_locked;
   ltssm_t    ltssmstate;
   logic      dlup_exit;
   logic      hotrst_exit;
   logic      l2_exit;
   cfg_addr_t tl_cfg_add;
   cfg_ctl_t  tl_cfg_ctl;
   ast_beat_t rx_drv;
   logic      rx_st_valid;
   logic      tx_st_ready;
   logic      app_rstn;
   logic      crst;
   logic      srst;
   busdev_t   cfg_busdev;
   logic      rx_st_ready;
   data_t     tx_st_data;
   logic      tx_st_sop;
   logic      tx_st_eop;
   empty_t    tx_st_empty;
   logic      tx_st_err;
   logic      tx_st_valid;
   ast_beat_t tx_seen;

   integer    seed = 40981;
   int        err_count = 0;
   int        check_count = 0;
   int        rx_count = 0;
   int        tx_count = 0;
   logic      rx_take = 1'b0;
   ast_beat_t pend_q[$];
   busdev_t   model_busdev = '0;
   cfg_addr_t model_add = '0;
   cfg_ctl_t  ctl;

   always #(clk_period / 2) pld_clk = ~pld_clk;

   pcie_ep_top dut (
      .pld_clk       (pld_clk),
      .npor          (npor),
      .rc_pll_locked (rc_pll_locked),
      .ltssmstate    (ltssmstate),
      .dlup_exit     (dlup_exit),
      .hotrst_exit   (hotrst_exit),
      .l2_exit       (l2_exit),
      .tl_cfg_add    (tl_cfg_add),
      .tl_cfg_ctl    (tl_cfg_ctl),
      .rx_st_data    (rx_drv.data),
      .rx_st_sop     (rx_drv.sop),
      .rx_st_eop     (rx_drv.eop),
      .rx_st_empty   (rx_drv.empty),
      .rx_st_err     (rx_drv.err),
      .rx_st_valid   (rx_st_valid),
      .tx_st_ready   (tx_st_ready),
      .app_rstn      (app_rstn),
      .crst          (crst),
      .srst          (srst),
      .cfg_busdev    (cfg_busdev),
      .rx_st_ready   (rx_st_ready),
      .tx_st_data    (tx_st_data),
      .tx_st_sop     (tx_st_sop),
      .tx_st_eop     (tx_st_eop),
      .tx_st_empty   (tx_st_empty),
      .tx_st_err     (tx_st_err),
      .tx_st_valid   (tx_st_valid)
   );

   assign tx_seen = {tx_st_data, tx_st_sop, tx_st_eop, tx_st_empty, tx_st_err};

   // busdev is taken on the second edge of a held busdev address
   function automatic busdev_t expect_busdev(busdev_t cur, cfg_addr_t prev_add,
                                             cfg_addr_t add, cfg_ctl_t word);
      if (add == prev_add && add == cfg_addr_busdev) begin
         return busdev_t'(word);
      end
      return cur;
   endfunction

   task automatic check(input string name, input cmp_t got, input cmp_t exp);
      check_count++;
      if (got !== exp) begin
         $display("error: %s got %h expected %h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic tick();
      @(posedge pld_clk);
      #2;
   endtask

   task automatic wait_crst_low(input int limit);
      int n;
      n = 0;
      while (crst && n < limit) begin
         tick();
         n++;
      end
      if (crst) begin
         $display("error: crst did not fall within %0d cycles", limit);
         err_count++;
      end
   endtask

   // one cfg bus cycle, the model follows the sampled address
   task automatic cfg_cycle(input cfg_addr_t add, input cfg_ctl_t word);
      tl_cfg_add = add;
      tl_cfg_ctl = word;
      tick();
      model_busdev = expect_busdev(model_busdev, model_add, add, word);
      model_add    = add;
   endtask

   // every tx transfer must match the oldest accepted rx beat
   task automatic compare_tx();
      ast_beat_t expected;
      forever begin
         @(negedge pld_clk);
         rx_take = rx_st_valid && rx_st_ready;
         if (npor && tx_st_valid && tx_st_ready) begin
            if (pend_q.size() == 0) begin
               $display("error: tx transfer seen with no accepted rx beat pending");
               err_count++;
            end else begin
               expected = pend_q.pop_front();
               check("tx beat", cmp_t'(tx_seen), cmp_t'(expected));
               tx_count++;
            end
         end
         if (rx_take) begin
            pend_q.push_back(rx_drv);
            rx_count++;
         end
      end
   endtask

   // valid holds until the beat is taken
   task automatic send_beats(input int n);
      int          offered;
      int          base;
      logic [31:0] rnd;
      offered = 0;
      base    = rx_count;
      while (rx_count - base < n) begin
         rnd = $random(seed);
         if (!rx_st_valid || rx_take) begin
            if (offered < n && rnd[5:4] != 2'b00) begin
               rx_drv.data  = {$random(seed), $random(seed)};
               rx_drv.sop   = rnd[0];
               rx_drv.eop   = rnd[1];
               rx_drv.empty = rnd[2];
               rx_drv.err   = rnd[3];
               rx_st_valid  = 1'b1;
               offered++;
            end else begin
               rx_st_valid = 1'b0;
            end
         end
         tx_st_ready = (rnd[7:6] != 2'b00);
         tick();
      end
      rx_st_valid = 1'b0;
   endtask

   initial begin
      #(40 * stim_cycles * clk_period);
      $display("timeout: simulation did not finish within %0d cycles",
               40 * stim_cycles);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      int base;
      npor          = 1'b0;
      rc_pll_locked = 1'b1;
      ltssmstate    = 5'h01;
      dlup_exit     = 1'b1;
      hotrst_exit   = 1'b1;
      l2_exit       = 1'b1;
      tl_cfg_add    = '0;
      tl_cfg_ctl    = '0;
      rx_drv        = '0;
      rx_st_valid   = 1'b0;
      tx_st_ready   = 1'b0;
      fork
         compare_tx();
      join_none
      repeat (5) tick();
      npor = 1'b1;

      // reset release, link not yet in L0
      wait_crst_low(rst_hold_cycles + 4);
      repeat (4) begin
         tick();
         check("app_rstn", cmp_t'(app_rstn), cmp_t'(1'b0));
      end
      ltssmstate = ltssm_l0;
      for (int k = 1; k <= l0_stable_cycles + 1; k++) begin
         tick();
         check("app_rstn", cmp_t'(app_rstn), cmp_t'(k == l0_stable_cycles + 1));
      end

      // one-cycle dlup_exit pulse
      dlup_exit = 1'b0;
      for (int k = 1; k <= rst_hold_cycles + 1; k++) begin
         tick();
         dlup_exit = 1'b1;
         check("crst", cmp_t'(crst), cmp_t'(k <= rst_hold_cycles));
         check("srst", cmp_t'(srst), cmp_t'(k <= rst_hold_cycles));
         check("app_rstn", cmp_t'(app_rstn), cmp_t'(1'b0));
      end
      for (int k = 1; k <= l0_stable_cycles + 1; k++) begin
         tick();
         check("app_rstn", cmp_t'(app_rstn), cmp_t'(k == l0_stable_cycles + 1));
      end

      // busdev held three cycles, then a single-cycle step
      cfg_cycle('0, '0);
      ctl = $random(seed);
      repeat (3) cfg_cycle(cfg_addr_busdev, ctl);
      cfg_cycle('0, ctl);
      check("cfg_busdev", cmp_t'(cfg_busdev), cmp_t'(model_busdev));
      check("cfg_busdev", cmp_t'(cfg_busdev), cmp_t'(busdev_t'(ctl)));
      cfg_cycle(cfg_addr_busdev, ~ctl);
      cfg_cycle('0, ~ctl);
      check("cfg_busdev", cmp_t'(cfg_busdev), cmp_t'(model_busdev));

      // bus master clear, rx offered
      ctl = $random(seed);
      ctl[bus_master_bit] = 1'b0;
      repeat (3) cfg_cycle(cfg_addr_prmcsr, ctl);
      cfg_cycle('0, ctl);
      rx_drv.data = {$random(seed), $random(seed)};
      rx_st_valid = 1'b1;
      tx_st_ready = 1'b1;
      repeat (6) begin
         tick();
         check("rx_st_ready", cmp_t'(rx_st_ready), cmp_t'(1'b0));
         check("tx_st_valid", cmp_t'(tx_st_valid), cmp_t'(1'b0));
      end
      rx_st_valid = 1'b0;
      ctl[bus_master_bit] = 1'b1;
      repeat (3) cfg_cycle(cfg_addr_prmcsr, ctl);
      cfg_cycle('0, ctl);
      base        = rx_count;
      rx_st_valid = 1'b1;
      tick();
      rx_st_valid = 1'b0;
      tick();
      check("accepted beats", cmp_t'(rx_count - base), cmp_t'(1));

      // random loopback traffic, then drain
      send_beats(200);
      tx_st_ready = 1'b1;
      repeat (4) tick();
      check("pending beats", cmp_t'(pend_q.size()), cmp_t'(0));

      $display("checks %0d, errors %0d, assertion failures %0d, beats %0d",
               check_count, err_count, dut.chk.fail_cnt, tx_count);
      if (err_count == 0 && dut.chk.fail_cnt == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: verilog.f
src/pcie_ep_pkg.sv
src/pcie_reset_seq.sv
src/tl_cfg_sample.sv
src/ast_loopback.sv
src/pcie_ep_top.sv
test/pcie_ep_asserts.sv
test/tb_pcie_ep_top.sv
